//--- a25_wb_pkg.sv
// ==========================================================
// shared widths, address views and state types for the
// wishbone bus master of the processor core
// ==========================================================
package a25_wb_pkg;

    // bus widths, one select line per byte lane
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // words moved by one cache line fill
    localparam int BURST_LEN = 4;

    // a cache line is 16 bytes, so the address splits into
    // a line index, a word inside the line and a byte inside the word
    localparam int BYTE_W = 2;
    localparam int WORD_W = 2;
    localparam int LINE_W = ADDR_W - WORD_W - BYTE_W;

    // the bus address seen either as one flat value or as its fields
    // the burst logic steps the word field and the selector writes the byte field
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [LINE_W-1:0] line;
            logic [WORD_W-1:0] word;
            logic [BYTE_W-1:0] byte_off;
        } f;
    } wb_addr_u;

    // read cycle state, burst states are numbered by the acknowledge they wait for
    typedef enum logic [2:0] {
        WB_IDLE     = 3'd0,
        WB_BURST1   = 3'd1,
        WB_BURST2   = 3'd2,
        WB_BURST3   = 3'd3,
        WB_WAIT_ACK = 3'd4
    } wb_state_e;

    // requester that owns the current grant
    typedef enum logic [1:0] {
        NONE        = 2'd0,
        DC_CACHED   = 2'd1,
        DC_UNCACHED = 2'd2,
        ICACHE      = 2'd3
    } wb_src_e;

endpackage

//--- a25_wb_select.sv
// ==========================================================
// request arbitration between the caches, plus the byte lane
// select and low address bits of the access to start
// ==========================================================
module a25_wb_select
    import a25_wb_pkg::*;
(
    input  logic              i_icache_req,
    input  logic              i_icache_qword,
    input  logic [ADDR_W-1:0] i_icache_address,
    input  logic              i_dcache_cached_req,
    input  logic              i_dcache_uncached_req,
    input  logic              i_dcache_qword,
    input  logic              i_dcache_write,
    input  logic [SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [ADDR_W-1:0] i_dcache_address,
    output wb_src_e           o_grant,
    output logic              o_grant_write,
    output logic              o_grant_burst,
    output wb_addr_u          o_start_addr,
    output logic [SEL_W-1:0]  o_start_sel
);

    // any request from the data cache, cached or not
    logic              dcache_req;
    // byte offset implied by the write byte enables
    logic [BYTE_W-1:0] lane_off;

    assign dcache_req = i_dcache_cached_req | i_dcache_uncached_req;

    // the data cache always wins, the instruction cache waits for a free slot
    always_comb
    begin
        if (i_dcache_cached_req)
            o_grant = DC_CACHED;
        else if (i_dcache_uncached_req)
            o_grant = DC_UNCACHED;
        else if (i_icache_req)
            o_grant = ICACHE;
        else
            o_grant = NONE;
    end

    // only the data cache ever writes
    assign o_grant_write = dcache_req & i_dcache_write;

    // line fills come from cached data reads or from the instruction cache
    // an uncached read is always a single word whatever its qword flag says
    assign o_grant_burst = (i_dcache_cached_req & ~i_dcache_write & i_dcache_qword) |
                           (~dcache_req & i_icache_req & i_icache_qword);

    // a single byte points at its own lane, an upper halfword at lane 2
    // the lower halfword, a full word and odd patterns all use offset 0
    always_comb
    begin
        case (i_dcache_byte_enable)
            4'b0001: lane_off = 2'd0;
            4'b0010: lane_off = 2'd1;
            4'b0100: lane_off = 2'd2;
            4'b1000: lane_off = 2'd3;
            4'b1100: lane_off = 2'd2;
            default: lane_off = 2'd0;
        endcase
    end

    // start address of the access, the low bits are filled in here
    // so the cycle controller can load it straight onto the bus
    always_comb
    begin
        o_start_addr.flat = dcache_req ? i_dcache_address : i_icache_address;
        // reads are whole words, so the byte offset is cleared
        o_start_addr.f.byte_off = o_grant_write ? lane_off : '0;
        // reads take every lane, writes only the enabled ones
        o_start_sel = o_grant_write ? i_dcache_byte_enable : '1;
    end

endmodule

//--- a25_wb_cycle_ctrl.sv
// ==========================================================
// wishbone cycle FSM with wrapping burst address stepping,
// posted write tracking and ready pulse generation
// ==========================================================
module a25_wb_cycle_ctrl
    import a25_wb_pkg::*;
#(
    parameter int BURST_LEN = a25_wb_pkg::BURST_LEN
)
(
    input  logic              i_clk,
    input  logic              quick_n_reset,
    input  wb_src_e           i_grant,
    input  logic              i_grant_write,
    input  logic              i_grant_burst,
    input  wb_addr_u          i_start_addr,
    input  logic [SEL_W-1:0]  i_start_sel,
    input  logic              i_exclusive,
    input  logic [DATA_W-1:0] i_write_data,
    input  logic              i_wb_ack,
    output logic [ADDR_W-1:0] o_wb_adr,
    output logic [SEL_W-1:0]  o_wb_sel,
    output logic              o_wb_we,
    output logic [DATA_W-1:0] o_wb_dat,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    output logic              o_icache_ready,
    output logic              o_dcache_cached_ready,
    output logic              o_dcache_uncached_ready
);

    wb_state_e state_r;
    // state after an acknowledge in one of the burst states
    wb_state_e burst_next;
    // source whose read is on the bus, NONE while idle or writing
    wb_src_e   serving_r;
    // the last access was the read half of a swap
    logic      exclusive_r;
    // bus address, stepped in its word field during a burst
    wb_addr_u  adr_r;

    logic      write_busy;
    logic      start;
    logic      read_ack;
    logic      in_burst;

    assign o_wb_adr = adr_r.flat;

    // ==========================================================
    // handshake decode
    // ==========================================================

    // a posted write keeps the bus until its acknowledge arrives
    // in the acknowledge cycle itself the next access may already be taken
    assign write_busy = o_wb_stb & o_wb_we & ~i_wb_ack;

    // new accesses are only taken from idle with the bus free
    assign start = (state_r == WB_IDLE) & ~write_busy & (i_grant != NONE);

    // acknowledge of a read beat, writes never produce read readies
    assign read_ack = o_wb_stb & ~o_wb_we & i_wb_ack;

    assign in_burst = (state_r == WB_BURST1) | (state_r == WB_BURST2) |
                      (state_r == WB_BURST3);

    // the burst states count acknowledges up to BURST_LEN - 1 and the
    // final beat is taken in the wait state like any single read
    assign burst_next = (state_r == wb_state_e'(3'(BURST_LEN - 1))) ?
                        WB_WAIT_ACK : wb_state_e'(state_r + 3'd1);

    // read readies follow each acknowledge for the source being served
    // write readies pulse in the cycle the write is taken
    assign o_icache_ready = read_ack & (serving_r == ICACHE);

    assign o_dcache_cached_ready =
        (read_ack & (serving_r == DC_CACHED)) |
        (start & i_grant_write & (i_grant == DC_CACHED));

    assign o_dcache_uncached_ready =
        (read_ack & (serving_r == DC_UNCACHED)) |
        (start & i_grant_write & (i_grant == DC_UNCACHED));

    // ==========================================================
    // cycle FSM
    // ==========================================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r     <= WB_IDLE;
            serving_r   <= NONE;
            exclusive_r <= 1'b0;
            o_wb_cyc    <= 1'b0;
            o_wb_stb    <= 1'b0;
            o_wb_we     <= 1'b0;
        end
        else
        begin
            case (state_r)
                WB_IDLE:
                begin
                    if (start)
                    begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= i_grant_write;
                        // swaps only come from the data side
                        exclusive_r <= i_exclusive & (i_grant != ICACHE);
                        // writes are posted, the FSM stays idle while they run
                        if (!i_grant_write)
                        begin
                            serving_r <= i_grant;
                            state_r   <= i_grant_burst ? WB_BURST1 : WB_WAIT_ACK;
                        end
                    end
                    else if (!write_busy)
                    begin
                        // bus goes quiet, but a swap keeps the cycle line
                        // high so no other master can slip in
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                        o_wb_cyc <= exclusive_r;
                    end
                end

                WB_BURST1, WB_BURST2, WB_BURST3:
                begin
                    // strobe stays high across the burst beats
                    if (i_wb_ack)
                        state_r <= burst_next;
                end

                WB_WAIT_ACK:
                begin
                    if (i_wb_ack)
                    begin
                        state_r   <= WB_IDLE;
                        serving_r <= NONE;
                        o_wb_stb  <= 1'b0;
                        o_wb_we   <= 1'b0;
                        o_wb_cyc  <= exclusive_r;
                    end
                end

                default:
                begin
                    state_r   <= WB_IDLE;
                    serving_r <= NONE;
                end
            endcase
        end
    end

    // ==========================================================
    // address, select and write data
    // ==========================================================

    // loaded only when an access starts, so they hold under back-pressure
    always_ff @(posedge i_clk)
    begin
        if (start)
        begin
            adr_r    <= i_start_addr;
            o_wb_sel <= i_start_sel;
            if (i_grant_write)
                o_wb_dat <= i_write_data;
        end
        else if (in_burst && read_ack)
        begin
            // wrap inside the 16 byte line, the line index never moves
            adr_r.f.word <= adr_r.f.word + WORD_W'(1);
        end
    end

endmodule

//--- a25_wishbone.sv
// ==========================================================
// wishbone bus master top, cache request selection feeding
// the bus cycle controller
// ==========================================================
module a25_wishbone
    import a25_wb_pkg::*;
#(
    parameter int BURST_LEN = a25_wb_pkg::BURST_LEN
)
(
    input  logic              i_clk,
    input  logic              quick_n_reset,

    // instruction cache side
    input  logic              i_icache_req,
    input  logic              i_icache_qword,
    input  logic [ADDR_W-1:0] i_icache_address,
    output logic [DATA_W-1:0] o_icache_read_data,
    output logic              o_icache_ready,

    // data cache side, exclusive marks the read half of a swap
    input  logic              i_exclusive,
    input  logic              i_dcache_cached_req,
    input  logic              i_dcache_uncached_req,
    input  logic              i_dcache_qword,
    input  logic              i_dcache_write,
    input  logic [DATA_W-1:0] i_dcache_write_data,
    input  logic [SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [ADDR_W-1:0] i_dcache_address,
    output logic [DATA_W-1:0] o_dcache_read_data,
    output logic              o_dcache_cached_ready,
    output logic              o_dcache_uncached_ready,

    // wishbone bus
    output logic [ADDR_W-1:0] o_wb_adr,
    output logic [SEL_W-1:0]  o_wb_sel,
    output logic              o_wb_we,
    input  logic [DATA_W-1:0] i_wb_dat,
    output logic [DATA_W-1:0] o_wb_dat,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    input  logic              i_wb_ack
);

    wb_src_e          grant;
    logic             grant_write;
    logic             grant_burst;
    wb_addr_u         start_addr;
    logic [SEL_W-1:0] start_sel;

    // both caches see the bus data directly, the readies say when it is theirs
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

    a25_wb_select u_select (
        .i_icache_req          (i_icache_req),
        .i_icache_qword        (i_icache_qword),
        .i_icache_address      (i_icache_address),
        .i_dcache_cached_req   (i_dcache_cached_req),
        .i_dcache_uncached_req (i_dcache_uncached_req),
        .i_dcache_qword        (i_dcache_qword),
        .i_dcache_write        (i_dcache_write),
        .i_dcache_byte_enable  (i_dcache_byte_enable),
        .i_dcache_address      (i_dcache_address),
        .o_grant               (grant),
        .o_grant_write         (grant_write),
        .o_grant_burst         (grant_burst),
        .o_start_addr          (start_addr),
        .o_start_sel           (start_sel)
    );

    a25_wb_cycle_ctrl #(
        .BURST_LEN (BURST_LEN)
    ) u_cycle_ctrl (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_grant                 (grant),
        .i_grant_write           (grant_write),
        .i_grant_burst           (grant_burst),
        .i_start_addr            (start_addr),
        .i_start_sel             (start_sel),
        .i_exclusive             (i_exclusive),
        .i_write_data            (i_dcache_write_data),
        .i_wb_ack                (i_wb_ack),
        .o_wb_adr                (o_wb_adr),
        .o_wb_sel                (o_wb_sel),
        .o_wb_we                 (o_wb_we),
        .o_wb_dat                (o_wb_dat),
        .o_wb_cyc                (o_wb_cyc),
        .o_wb_stb                (o_wb_stb),
        .o_icache_ready          (o_icache_ready),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready)
    );

endmodule

//--- tb_wb_slave.sv
// ==========================================================
// wishbone slave memory for the testbench, one acknowledge
// per strobed word after a settable number of wait cycles
// ==========================================================
module tb_wb_slave
    import a25_wb_pkg::*;
(
    input  logic              i_clk,
    input  logic              quick_n_reset,
    input  logic              i_cyc,
    input  logic              i_stb,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_adr,
    input  logic [SEL_W-1:0]  i_sel,
    input  logic [DATA_W-1:0] i_dat,
    input  logic [1:0]        i_delay,
    output logic              o_ack,
    output logic [DATA_W-1:0] o_dat
);

    // 64 words, so address bits 7 to 2 pick the word
    logic [DATA_W-1:0] mem [64];
    logic [1:0]        wait_cnt;

    // every word starts with a value built from its own index
    initial
    begin
        for (int i = 0; i < 64; i++)
            mem[i] = (32'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c;
    end

    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_ack    <= 1'b0;
            wait_cnt <= 2'd0;
        end
        else if (o_ack)
        begin
            // one acknowledge per word, then count again for the next beat
            o_ack    <= 1'b0;
            wait_cnt <= 2'd0;
        end
        else if (i_cyc && i_stb)
        begin
            if (wait_cnt == i_delay)
            begin
                o_ack <= 1'b1;
                if (i_we)
                begin
                    for (int b = 0; b < SEL_W; b++)
                        if (i_sel[b])
                            mem[i_adr[7:2]][8*b +: 8] <= i_dat[8*b +: 8];
                end
                else
                    o_dat <= mem[i_adr[7:2]];
            end
            else
                wait_cnt <= wait_cnt + 2'd1;
        end
    end

endmodule

//--- a25_wb_props.sv
// ==========================================================
// bus and burst state checks on the cycle controller
// ==========================================================
module a25_wb_props
    import a25_wb_pkg::*;
(
    input logic              i_clk,
    input logic              quick_n_reset,
    input wb_state_e         state_r,
    input logic              o_wb_cyc,
    input logic              o_wb_stb,
    input logic              i_wb_ack,
    input logic [ADDR_W-1:0] o_wb_adr
);

    // a strobe is only legal inside a bus cycle
    p_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb |-> o_wb_cyc) else $error("strobe high outside a bus cycle");

    // burst states only move forward, one acknowledge at a time
    p_burst1: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state_r == WB_BURST1 |=> state_r inside {WB_BURST1, WB_BURST2})
        else $error("bad state after the first burst state");
    p_burst2: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state_r == WB_BURST2 |=> state_r inside {WB_BURST2, WB_BURST3})
        else $error("bad state after the second burst state");
    p_burst3: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state_r == WB_BURST3 |=> state_r inside {WB_BURST3, WB_WAIT_ACK})
        else $error("bad state after the third burst state");

    // a waiting strobe keeps its address
    p_adr_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb && !i_wb_ack |=> $stable(o_wb_adr))
        else $error("address moved while the strobe waited");

endmodule

bind a25_wb_cycle_ctrl a25_wb_props u_props (
    .i_clk         (i_clk),
    .quick_n_reset (quick_n_reset),
    .state_r       (state_r),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_stb      (o_wb_stb),
    .i_wb_ack      (i_wb_ack),
    .o_wb_adr      (o_wb_adr)
);

//--- tb_a25_wishbone.sv
// ==========================================================
// testbench for the wishbone bus master, random cache traffic
// against a slave memory and a reference memory model
// ==========================================================
module tb_a25_wishbone
    import a25_wb_pkg::*;
;
    localparam int NUM_OPS  = 300;
    // worst op is a dual request with a burst, five cycles per word
    localparam int WATCHDOG = (NUM_OPS * 2 * BURST_LEN * 5 + 100) * 100;

    logic              i_clk, quick_n_reset, i_icache_req, i_icache_qword, i_exclusive;
    logic [ADDR_W-1:0] i_icache_address, i_dcache_address, o_wb_adr;
    logic              i_dcache_cached_req, i_dcache_uncached_req, i_dcache_qword;
    logic              i_dcache_write, o_icache_ready, o_dcache_cached_ready;
    logic              o_dcache_uncached_ready, o_wb_we, o_wb_cyc, o_wb_stb, i_wb_ack;
    logic [DATA_W-1:0] i_dcache_write_data, o_icache_read_data, o_dcache_read_data;
    logic [DATA_W-1:0] i_wb_dat, o_wb_dat;
    logic [SEL_W-1:0]  i_dcache_byte_enable, o_wb_sel;
    logic [1:0]        slave_delay;
    logic [31:0]       lfsr, model [64];
    int                checks, errors;

    a25_wishbone #(.BURST_LEN(BURST_LEN)) uut (.*);

    tb_wb_slave u_slave (.i_clk(i_clk), .quick_n_reset(quick_n_reset), .i_cyc(o_wb_cyc),
        .i_stb(o_wb_stb), .i_we(o_wb_we), .i_adr(o_wb_adr), .i_sel(o_wb_sel),
        .i_dat(o_wb_dat), .i_delay(slave_delay), .o_ack(i_wb_ack), .o_dat(i_wb_dat));

    always #50 i_clk = ~i_clk;

    // galois LFSR, one step for each bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // byte offset a write should carry on the bus for its enables
    function automatic logic [1:0] lane_of(input logic [3:0] be);
        logic [1:0] lane;
        lane = 2'd0;
        if ($countones(be) == 1)
        begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    lane = 2'(b);
        end
        else if (be == 4'b1100)
            lane = 2'd2;
        return lane;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic clear_inputs();
        {i_icache_req, i_icache_qword, i_exclusive, i_dcache_cached_req} = '0;
        {i_dcache_uncached_req, i_dcache_qword, i_dcache_write} = '0;
    endtask

    // src 2 is the instruction cache, 1 cached data, 0 uncached data
    task automatic wait_read(input int src, input int beats, input logic [31:0] addr);
        logic [2:0]  rdy;
        logic [31:0] exp_adr;
        int          got;
        got = 0;
        while (got < beats)
        begin
            @(posedge i_clk);
            rdy = {o_icache_ready, o_dcache_cached_ready, o_dcache_uncached_ready};
            check_val("other ready outputs", 32'(rdy & ~(3'b1 << src)), 32'd0);
            if (rdy[src])
            begin
                // wrapping beat order inside the 16 byte line
                exp_adr = {addr[31:4], addr[3:2] + 2'(got), 2'b00};
                check_val("i_wb_ack", 32'(i_wb_ack), 32'd1);
                check_val("o_wb_adr", o_wb_adr, exp_adr);
                // reads take every byte lane
                check_val("o_wb_sel", 32'(o_wb_sel), 32'hf);
                check_val(src == 2 ? "o_icache_read_data" : "o_dcache_read_data",
                          src == 2 ? o_icache_read_data : o_dcache_read_data,
                          model[exp_adr[7:2]]);
                got++;
            end
        end
    endtask

    task automatic wait_write(input int src);
        logic [2:0] rdy;
        rdy = '0;
        while (!rdy[src])
        begin
            @(posedge i_clk);
            rdy = {o_icache_ready, o_dcache_cached_ready, o_dcache_uncached_ready};
            check_val("other ready outputs", 32'(rdy & ~(3'b1 << src)), 32'd0);
        end
        for (int b = 0; b < 4; b++)
            if (i_dcache_byte_enable[b])
                model[i_dcache_address[7:2]][8*b +: 8] = i_dcache_write_data[8*b +: 8];
        // the write strobe rises on the edge that took the write
        @(posedge i_clk);
        check_val("o_wb_stb and o_wb_we", 32'(o_wb_stb & o_wb_we), 32'd1);
        check_val("o_wb_adr", o_wb_adr,
                  {i_dcache_address[31:2], lane_of(i_dcache_byte_enable)});
        check_val("o_wb_sel", 32'(o_wb_sel), 32'(i_dcache_byte_enable));
        check_val("o_wb_dat", o_wb_dat, i_dcache_write_data);
    endtask

    task automatic run_op();
        logic [2:0] kind;
        logic       qw;
        kind = 3'(rand_bits(3));
        qw = rand_bits(1) == 32'd1;
        slave_delay = 2'(rand_bits(2));
        i_dcache_address = rand_bits(32);
        i_icache_address = rand_bits(32);
        i_dcache_write_data = rand_bits(32);
        i_dcache_byte_enable = 4'(rand_bits(4));
        if (i_dcache_byte_enable == 4'd0)
            i_dcache_byte_enable = 4'hf;
        case (kind)
            3'd0, 3'd1:
            begin
                {i_icache_req, i_icache_qword} = {1'b1, qw};
                wait_read(2, qw ? BURST_LEN : 1, i_icache_address);
            end
            3'd2, 3'd3:
            begin
                {i_dcache_cached_req, i_dcache_qword} = {1'b1, qw};
                wait_read(1, qw ? BURST_LEN : 1, i_dcache_address);
            end
            3'd4:
            begin
                // an uncached qword flag still gives a single word
                {i_dcache_uncached_req, i_dcache_qword} = {1'b1, qw};
                wait_read(0, 1, i_dcache_address);
            end
            3'd5:
            begin
                {i_dcache_cached_req, i_dcache_uncached_req} = {qw, ~qw};
                i_dcache_write = 1'b1;
                wait_write(qw ? 1 : 0);
            end
            3'd6:
            begin
                {i_dcache_uncached_req, i_exclusive} = 2'b11;
                wait_read(0, 1, i_dcache_address);
                @(negedge i_clk);
                clear_inputs();
                // swap keeps the bus owned with the strobe low
                @(posedge i_clk);
                check_val("o_wb_cyc after swap", 32'(o_wb_cyc), 32'd1);
                check_val("o_wb_stb after swap", 32'(o_wb_stb), 32'd0);
            end
            default:
            begin
                // both caches at once, the data side must finish first
                {i_icache_req, i_icache_qword, i_dcache_uncached_req} = {1'b1, qw, 1'b1};
                wait_read(0, 1, i_dcache_address);
                @(negedge i_clk);
                i_dcache_uncached_req = 1'b0;
                wait_read(2, qw ? BURST_LEN : 1, i_icache_address);
            end
        endcase
        @(negedge i_clk);
        clear_inputs();
    endtask

    initial
    begin
        #(WATCHDOG);
        $display("watchdog expired, a ready pulse never arrived and the run was stopped");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        lfsr = 32'h72d8075c;
        {checks, errors} = '0;
        {i_clk, quick_n_reset, slave_delay} = '0;
        clear_inputs();
        {i_icache_address, i_dcache_address, i_dcache_write_data} = '0;
        i_dcache_byte_enable = '0;
        for (int i = 0; i < 64; i++)
            model[i] = (32'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c;
        repeat (10) @(posedge i_clk);
        check_val("o_wb_cyc in reset", 32'(o_wb_cyc), 32'd0);
        check_val("o_wb_stb in reset", 32'(o_wb_stb), 32'd0);
        check_val("o_wb_we in reset", 32'(o_wb_we), 32'd0);
        check_val("ready outputs in reset", 32'({o_icache_ready, o_dcache_cached_ready,
                  o_dcache_uncached_ready}), 32'd0);
        @(negedge i_clk);
        quick_n_reset = 1'b1;
        repeat (NUM_OPS) run_op();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim.f
a25_wb_pkg.sv
a25_wb_select.sv
a25_wb_cycle_ctrl.sv
a25_wishbone.sv
tb_wb_slave.sv
a25_wb_props.sv
tb_a25_wishbone.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_a25_wishbone
FLIST = sim.f
MDIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(MDIR)
	./$(MDIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(MDIR)
